// ==== Bender.yml ====
package:
  name: stream_mux

sources:
  - files:
      - rtl/stream_mux_pkg.sv
      - rtl/stream_fifo.sv
      - rtl/port_mux.sv
      - rtl/pkt_arbiter.sv
      - rtl/stream_mux_top.sv
  - target: test
    files:
      - tests/tb_stream_mux.sv

// ==== rtl/pkt_arbiter.sv ====
// packet arbiter, grants one whole packet at a time
// scans one port per cycle, one bubble cycle follows each packet
// packet ends come from i_pkt_done only, beat contents are never inspected
`timescale 1ns/10ps
`default_nettype none

module pkt_arbiter (
   input  wire                                       clk,
   input  wire                                       reset,
   input  wire                                       i_clear,
   input  stream_mux_pkg::mux_mode_e                 i_mode,
   input  wire  [stream_mux_pkg::NUM_PORTS-1:0]      i_buf_valid,
   input  wire                                       i_pkt_done,
   output stream_mux_pkg::port_idx_t                 o_grant_port,
   output logic                                      o_grant_active
);

   stream_mux_pkg::arb_state_e state;
   stream_mux_pkg::port_idx_t  cur_port;
   stream_mux_pkg::port_idx_t  next_port;   // rotation successor
   stream_mux_pkg::port_idx_t  done_port;   // where to look after a packet

   always_comb
   begin
      if (cur_port == stream_mux_pkg::LAST_PORT)
      begin
         next_port = stream_mux_pkg::FIRST_PORT;
      end
      else
      begin
         next_port = cur_port + 1'b1;
      end
   end

   // priority mode always restarts the scan at port 0
   always_comb
   begin
      if (i_mode == stream_mux_pkg::MODE_PRIORITY)
      begin
         done_port = stream_mux_pkg::FIRST_PORT;
      end
      else
      begin
         done_port = next_port;
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset || i_clear)
      begin
         state    <= stream_mux_pkg::ARB_SCAN;
         cur_port <= stream_mux_pkg::FIRST_PORT;
      end
      else
      begin
         case (state)
            stream_mux_pkg::ARB_SCAN:
            begin
               if (i_buf_valid[cur_port])
               begin
                  state <= stream_mux_pkg::ARB_ACTIVE;   // grant this port
               end
               else
               begin
                  cur_port <= next_port;                 // try the next one
               end
            end
            stream_mux_pkg::ARB_ACTIVE:
            begin
               if (i_pkt_done)
               begin
                  state    <= stream_mux_pkg::ARB_SCAN;  // bubble cycle
                  cur_port <= done_port;
               end
            end
            default:
            begin
               state <= stream_mux_pkg::ARB_SCAN;
            end
         endcase
      end
   end

   assign o_grant_port   = cur_port;
   assign o_grant_active = (state == stream_mux_pkg::ARB_ACTIVE);

endmodule

`default_nettype wire

// ==== rtl/port_mux.sv ====
// steers the granted input buffer onto the merged stream
// purely combinational, the end of a packet is flagged on the last transfer
`timescale 1ns/10ps
`default_nettype none

module port_mux (
   // input buffers
   input  stream_mux_pkg::stream_beat_t [stream_mux_pkg::NUM_PORTS-1:0] i_buf_beat,
   input  wire  [stream_mux_pkg::NUM_PORTS-1:0]                         i_buf_valid,
   output logic [stream_mux_pkg::NUM_PORTS-1:0]                         o_buf_ready,
   // grant from the arbiter
   input  stream_mux_pkg::port_idx_t                                    i_grant_port,
   input  wire                                                          i_grant_active,
   // merged stream
   output stream_mux_pkg::stream_beat_t                                 o_beat,
   output logic                                                         o_valid,
   input  wire                                                          i_ready,
   output logic                                                         o_pkt_done
);

   logic xfer;

   assign o_beat  = i_buf_beat[i_grant_port];
   assign o_valid = i_grant_active & i_buf_valid[i_grant_port];
   assign xfer    = o_valid & i_ready;

   // only the packet's final beat ends the grant
   assign o_pkt_done = xfer & o_beat.last;

   // ready goes back to the granted port alone
   for (genvar p = 0; p < stream_mux_pkg::NUM_PORTS; p++)
   begin : g_ready
      assign o_buf_ready[p] = i_grant_active & i_ready &
                              (i_grant_port == stream_mux_pkg::port_idx_t'(p));
   end

endmodule

`default_nettype wire

// ==== rtl/stream_fifo.sv ====
// first-word-fall-through buffer for stream beats
// ready depends only on occupancy, never on i_ready
// i_clear empties the buffer, stored data is left as is
`timescale 1ns/10ps
`default_nettype none

module stream_fifo (
   input  wire                          clk,
   input  wire                          reset,
   input  wire                          i_clear,
   // write side
   input  stream_mux_pkg::stream_beat_t i_beat,
   input  wire                          i_valid,
   output logic                         o_ready,
   // read side
   output stream_mux_pkg::stream_beat_t o_beat,
   output logic                         o_valid,
   input  wire                          i_ready
);

   stream_mux_pkg::stream_beat_t mem [stream_mux_pkg::FIFO_DEPTH];

   stream_mux_pkg::fifo_ptr_t wr_ptr;
   stream_mux_pkg::fifo_ptr_t rd_ptr;
   stream_mux_pkg::fifo_cnt_t count;

   logic wr_en;
   logic rd_en;

   assign o_ready = (count != stream_mux_pkg::FIFO_FULL_CNT);
   assign o_valid = (count != '0);
   assign o_beat  = mem[rd_ptr];   // head always visible

   assign wr_en = i_valid & o_ready;
   assign rd_en = o_valid & i_ready;

   // storage, no reset needed
   always_ff @(posedge clk)
   begin
      if (wr_en)
      begin
         mem[wr_ptr] <= i_beat;
      end
   end

   // pointers and occupancy
   always_ff @(posedge clk)
   begin
      if (reset || i_clear)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (wr_en)
         begin
            wr_ptr <= wr_ptr + 1'b1;   // wraps at depth
         end
         if (rd_en)
         begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({wr_en, rd_en})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;   // none or both
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== rtl/stream_mux_pkg.sv ====
// shared sizes and types for the 4-port packet stream merger
// data width is fixed at 32, FIFO_DEPTH must be a power of two
`default_nettype none

package stream_mux_pkg;

   localparam int NUM_PORTS  = 4;     // input streams
   localparam int DATA_W     = 32;    // beat payload width
   localparam int FIFO_DEPTH = 4;     // entries per stream buffer

   localparam int PORT_W     = $clog2(NUM_PORTS);
   localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
   localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);

   // one beat on any stream link
   typedef struct packed {
      logic [DATA_W-1:0] data;
      logic              last;        // final beat of packet
   } stream_beat_t;

   typedef logic [PORT_W-1:0]     port_idx_t;
   typedef logic [FIFO_PTR_W-1:0] fifo_ptr_t;
   typedef logic [FIFO_CNT_W-1:0] fifo_cnt_t;

   localparam port_idx_t FIRST_PORT    = port_idx_t'(0);
   localparam port_idx_t LAST_PORT     = port_idx_t'(NUM_PORTS - 1);
   localparam fifo_cnt_t FIFO_FULL_CNT = fifo_cnt_t'(FIFO_DEPTH);

   // arbitration policy, selectable at run time
   typedef enum logic {
      MODE_ROUND_ROBIN = 1'b0,
      MODE_PRIORITY    = 1'b1       // port 0 highest
   } mux_mode_e;

   // arbiter control states
   typedef enum logic {
      ARB_SCAN   = 1'b0,           // looking for a waiting port
      ARB_ACTIVE = 1'b1            // packet in progress
   } arb_state_e;

endpackage

`default_nettype wire

// ==== rtl/stream_mux_top.sv ====
// four-input packet stream merger with buffered inputs and output
// minimum latency is three edges, more under arbitration or stalls
// i_mode may change between packets, i_clear restarts the grant at port 0
`timescale 1ns/10ps
`default_nettype none

module stream_mux_top (
   input  wire                                                          clk,
   input  wire                                                          reset,
   input  wire                                                          i_clear,
   input  stream_mux_pkg::mux_mode_e                                    i_mode,
   // sources
   input  stream_mux_pkg::stream_beat_t [stream_mux_pkg::NUM_PORTS-1:0] i_src_beat,
   input  wire  [stream_mux_pkg::NUM_PORTS-1:0]                         i_src_valid,
   output logic [stream_mux_pkg::NUM_PORTS-1:0]                         o_src_ready,
   // sink
   output stream_mux_pkg::stream_beat_t                                 o_dst_beat,
   output logic                                                         o_dst_valid,
   input  wire                                                          i_dst_ready
);

   stream_mux_pkg::stream_beat_t [stream_mux_pkg::NUM_PORTS-1:0] buf_beat;
   logic [stream_mux_pkg::NUM_PORTS-1:0] buf_valid;
   logic [stream_mux_pkg::NUM_PORTS-1:0] buf_ready;

   stream_mux_pkg::port_idx_t    grant_port;
   logic                         grant_active;
   stream_mux_pkg::stream_beat_t mux_beat;
   logic                         mux_valid;
   logic                         mux_ready;
   logic                         pkt_done;

   for (genvar p = 0; p < stream_mux_pkg::NUM_PORTS; p++)
   begin : g_in_buf
      stream_fifo in_buf (
         .clk     (clk),
         .reset   (reset),
         .i_clear (i_clear),
         .i_beat  (i_src_beat[p]),
         .i_valid (i_src_valid[p]),
         .o_ready (o_src_ready[p]),
         .o_beat  (buf_beat[p]),
         .o_valid (buf_valid[p]),
         .i_ready (buf_ready[p])
      );
   end

   port_mux port_mux_i (
      .i_buf_beat     (buf_beat),
      .i_buf_valid    (buf_valid),
      .o_buf_ready    (buf_ready),
      .i_grant_port   (grant_port),
      .i_grant_active (grant_active),
      .o_beat         (mux_beat),
      .o_valid        (mux_valid),
      .i_ready        (mux_ready),
      .o_pkt_done     (pkt_done)
   );

   pkt_arbiter pkt_arbiter_i (
      .clk            (clk),
      .reset          (reset),
      .i_clear        (i_clear),
      .i_mode         (i_mode),
      .i_buf_valid    (buf_valid),
      .i_pkt_done     (pkt_done),
      .o_grant_port   (grant_port),
      .o_grant_active (grant_active)
   );

   // output buffer decouples sink stalls from the arbiter
   stream_fifo out_buf (
      .clk     (clk),
      .reset   (reset),
      .i_clear (i_clear),
      .i_beat  (mux_beat),
      .i_valid (mux_valid),
      .o_ready (mux_ready),
      .o_beat  (o_dst_beat),
      .o_valid (o_dst_valid),
      .i_ready (i_dst_ready)
   );

endmodule

`default_nettype wire

// ==== src.f ====
rtl/stream_mux_pkg.sv
rtl/stream_fifo.sv
rtl/port_mux.sv
rtl/pkt_arbiter.sv
rtl/stream_mux_top.sv
tests/tb_stream_mux.sv

// ==== tests/stream_mux_golden.txt ====
// hex words; first the scenario count, then per scenario: mode stall,
// one line per port: packet count then (length start) pairs, then order count and ports
5
// scenario 1: round-robin, all ports loaded, no stalls
0 0
3 3 10000000 1 10000010 4 10000020
3 2 20000000 5 20000010 1 20000020
3 4 30000000 2 30000010 3 30000020
3 1 40000000 3 40000010 2 40000020
c
0 1 2 3 0 1 2 3 0 1 2 3

// scenario 2: priority, all ports backlogged
1 0
3 2 12000000 3 12000010 4 12000020
3 3 22000000 1 22000010 2 22000020
3 4 32000000 2 32000010 3 32000020
3 1 42000000 4 42000010 2 42000020
c
0 0 0 1 1 1 2 2 2 3 3 3

// scenario 3: round-robin with random sink stalls, longer packets
0 1
2 6 11000000 3 11000010
2 2 21000000 7 21000010
2 5 31000000 1 31000010
2 4 41000000 6 41000010
8
0 1 2 3 0 1 2 3

// scenario 4: round-robin, only ports 1 and 3 carry traffic
0 0
0
3 3 23000000 2 23000010 4 23000020
0
3 2 43000000 5 43000010 1 43000020
6
1 3 1 3 1 3

// scenario 5: scenario 1 again after clear, grant restarts at port 0
0 0
3 3 10000000 1 10000010 4 10000020
3 2 20000000 5 20000010 1 20000020
3 4 30000000 2 30000010 3 30000020
3 1 40000000 3 40000010 2 40000020
c
0 1 2 3 0 1 2 3 0 1 2 3

// ==== tests/tb_stream_mux.sv ====
// self-checking testbench for the 4-port packet stream merger
// stimulus and expected packet order come from tests/stream_mux_golden.txt
// sources start three cycles after each clear, when the scan is back at port 0
`timescale 1ns/10ps
`default_nettype none

module tb_stream_mux;

   localparam int TIMEOUT_CYC = 2000;   // per wait loop
   localparam int MAX_PKTS    = 8;      // per port and scenario
   localparam int MAX_ORDER   = 32;
   localparam int GOLDEN_SIZE = 512;

   logic                                                         clk;
   logic                                                         reset;
   logic                                                         clear;
   stream_mux_pkg::mux_mode_e                                    mode;
   stream_mux_pkg::stream_beat_t [stream_mux_pkg::NUM_PORTS-1:0] src_beat;
   logic [stream_mux_pkg::NUM_PORTS-1:0]                         src_valid;
   logic [stream_mux_pkg::NUM_PORTS-1:0]                         src_ready;
   stream_mux_pkg::stream_beat_t                                 dst_beat;
   logic                                                         dst_valid;
   logic                                                         dst_ready;

   logic [31:0]                       golden [GOLDEN_SIZE];
   int                                rd_idx;
   int                                pkt_cnt   [stream_mux_pkg::NUM_PORTS];
   int                                pkt_len   [stream_mux_pkg::NUM_PORTS][MAX_PKTS];
   logic [stream_mux_pkg::DATA_W-1:0] pkt_start [stream_mux_pkg::NUM_PORTS][MAX_PKTS];
   stream_mux_pkg::port_idx_t         exp_order [MAX_ORDER];
   int                                order_cnt;
   logic                              stall_en;
   logic                              sink_hold;
   logic [31:0]                       lcg_state;
   int                                err_count;
   int                                check_count;
   int                                scn_total;

   stream_mux_top stream_mux_top_i (
      .clk         (clk),
      .reset       (reset),
      .i_clear     (clear),
      .i_mode      (mode),
      .i_src_beat  (src_beat),
      .i_src_valid (src_valid),
      .o_src_ready (src_ready),
      .o_dst_beat  (dst_beat),
      .o_dst_valid (dst_valid),
      .i_dst_ready (dst_ready)
   );

   always #50 clk = ~clk;   // 100 ns period

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1103515245 + 32'd12345;
   endfunction

   // sink ready, held low before a clear, random stalls when the scenario asks
   always @(posedge clk)
   begin
      #5;
      if (sink_hold)
      begin
         dst_ready = 1'b0;
      end
      else if (stall_en)
      begin
         lcg_state = lcg_next(lcg_state);
         dst_ready = (lcg_state[17:16] != 2'b00);   // low one cycle in four
      end
      else
      begin
         dst_ready = 1'b1;
      end
   end

   task automatic read_word(output logic [31:0] w);
      w = golden[rd_idx];
      rd_idx++;
      if ($isunknown(w))
      begin
         $display("golden file ended early at word %0d", rd_idx - 1);
         err_count++;
         w = '0;
      end
   endtask

   task automatic load_scenario(output stream_mux_pkg::mux_mode_e scn_mode);
      logic [31:0] w;
      read_word(w);
      scn_mode = stream_mux_pkg::mux_mode_e'(w[0]);
      read_word(w);
      stall_en = w[0];
      for (int p = 0; p < stream_mux_pkg::NUM_PORTS; p++)
      begin
         read_word(w);
         pkt_cnt[p] = int'(w);
         for (int n = 0; n < pkt_cnt[p]; n++)
         begin
            read_word(w);
            pkt_len[p][n] = int'(w);
            read_word(w);
            pkt_start[p][n] = w;
         end
      end
      read_word(w);
      order_cnt = int'(w);
      for (int k = 0; k < order_cnt; k++)
      begin
         read_word(w);
         exp_order[k] = stream_mux_pkg::port_idx_t'(w);
      end
   endtask

   // all sources valid with the sink held, until every buffer is full
   task automatic fill_buffers();
      stream_mux_pkg::stream_beat_t junk;
      junk.data = 32'hdead_beef;
      junk.last = 1'b1;
      src_beat  = {stream_mux_pkg::NUM_PORTS{junk}};
      src_valid = '1;
      repeat (6 * stream_mux_pkg::FIFO_DEPTH) @(negedge clk);
      check_count++;
      if (dst_valid !== 1'b1)
      begin
         $display("Fail o_dst_valid: got %h expected 1 before clear", dst_valid);
         err_count++;
      end
      check_count++;
      if (src_ready !== '0)
      begin
         $display("Fail o_src_ready: got %h expected 0 before clear", src_ready);
         err_count++;
      end
      @(posedge clk);
      #5;
   endtask

   // pushes one port's packets back to back
   task automatic send_port(input int p);
      stream_mux_pkg::stream_beat_t beat;
      int                           waited;
      for (int n = 0; n < pkt_cnt[p]; n++)
      begin
         for (int b = 0; b < pkt_len[p][n]; b++)
         begin
            beat.data    = pkt_start[p][n] + b;   // beats count up
            beat.last    = (b == pkt_len[p][n] - 1);
            src_beat[p]  = beat;
            src_valid[p] = 1'b1;
            waited = 0;
            do
            begin
               @(negedge clk);
               waited++;
            end
            while (!src_ready[p] && waited < TIMEOUT_CYC);
            if (!src_ready[p])
            begin
               $display("port %0d source timed out waiting for ready", p);
               err_count++;
               src_valid[p] = 1'b0;
               return;
            end
            @(posedge clk);   // beat taken on this edge
            #5;
         end
      end
      src_valid[p] = 1'b0;
   endtask

   // takes output beats and checks them against the golden packet order
   task automatic collect_output();
      int                                seen [stream_mux_pkg::NUM_PORTS];
      int                                p;
      int                                n;
      int                                waited;
      logic                              got;
      logic [stream_mux_pkg::DATA_W-1:0] exp_data;
      logic                              exp_last;
      for (int i = 0; i < stream_mux_pkg::NUM_PORTS; i++)
      begin
         seen[i] = 0;
      end
      for (int k = 0; k < order_cnt; k++)
      begin
         p = exp_order[k];
         n = seen[p];   // next packet of that port
         seen[p]++;
         for (int b = 0; b < pkt_len[p][n]; b++)
         begin
            exp_data = pkt_start[p][n] + b;
            exp_last = (b == pkt_len[p][n] - 1);
            got    = 1'b0;
            waited = 0;
            while (!got && waited < TIMEOUT_CYC)
            begin
               @(negedge clk);
               got = dst_valid & dst_ready;
               waited++;
            end
            if (!got)
            begin
               $display("sink timed out waiting for packet %0d from port %0d", k, p);
               err_count++;
               return;
            end
            check_count++;
            if (dst_beat.data !== exp_data)
            begin
               $display("Fail o_dst_beat.data: got %h expected %h (packet %0d beat %0d)",
                        dst_beat.data, exp_data, k, b);
               err_count++;
            end
            if (dst_beat.last !== exp_last)
            begin
               $display("Fail o_dst_beat.last: got %h expected %h (packet %0d beat %0d)",
                        dst_beat.last, exp_last, k, b);
               err_count++;
            end
         end
      end
   endtask

   task automatic run_scenario(input int s);
      stream_mux_pkg::mux_mode_e scn_mode;
      @(negedge clk);
      load_scenario(scn_mode);
      $display("scenario %0d: mode %0d, stalls %0d, %0d packets",
               s, scn_mode, stall_en, order_cnt);
      sink_hold = 1'b1;   // clear must meet full buffers
      @(posedge clk);
      #5;
      fill_buffers();
      mode      = scn_mode;
      clear     = 1'b1;
      src_valid = '0;
      @(posedge clk);
      #5;
      clear = 1'b0;
      @(negedge clk);
      check_count++;
      if (dst_valid !== 1'b0)
      begin
         $display("Fail o_dst_valid: got %h expected 0 after clear", dst_valid);
         err_count++;
      end
      check_count++;
      if (src_ready !== {stream_mux_pkg::NUM_PORTS{1'b1}})
      begin
         $display("Fail o_src_ready: got %h expected f after clear", src_ready);
         err_count++;
      end
      sink_hold = 1'b0;
      // first beats land when the scan is at port 0
      repeat (3) @(posedge clk);
      #5;
      fork
         send_port(0);
         send_port(1);
         send_port(2);
         send_port(3);
         collect_output();
      join
      // nothing may follow the expected packets
      repeat (8)
      begin
         @(negedge clk);
         check_count++;
         if (dst_valid !== 1'b0)
         begin
            $display("Fail o_dst_valid: got %h expected 0 after last packet", dst_valid);
            err_count++;
         end
      end
   endtask

   initial
   begin
      clk         = 1'b0;
      reset       = 1'b1;
      clear       = 1'b0;
      mode        = stream_mux_pkg::MODE_ROUND_ROBIN;
      src_beat    = '0;
      src_valid   = '0;
      dst_ready   = 1'b1;
      stall_en    = 1'b0;
      sink_hold   = 1'b0;
      lcg_state   = 32'd74547;
      err_count   = 0;
      check_count = 0;
      rd_idx      = 1;
      $readmemh("tests/stream_mux_golden.txt", golden);
      if ($isunknown(golden[0]))
      begin
         $display("could not read the golden file");
         err_count++;
      end
      else
      begin
         repeat (8) @(posedge clk);
         #5;
         reset     = 1'b0;
         scn_total = int'(golden[0]);
         for (int s = 1; s <= scn_total; s++)
         begin
            run_scenario(s);
         end
      end
      $display("checks %0d, errors %0d", check_count, err_count);
      if (err_count == 0)
      begin
         $display("Finished with no errors");
      end
      else
      begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

`default_nettype wire
